/* hba_pkg.sv */
`default_nettype none

package hba_pkg;

    // bus widths
    localparam int DBUS_WIDTH        = 8;
    localparam int REG_ADDR_WIDTH    = 8;
    localparam int PERIPH_ADDR_WIDTH = 4;

    // peripheral slots, same numbering as the board
    localparam logic [PERIPH_ADDR_WIDTH-1:0] BASICIO_PERIPH = 1;
    localparam logic [PERIPH_ADDR_WIDTH-1:0] MOTOR_PERIPH   = 3;

    // register map
    localparam logic [REG_ADDR_WIDTH-1:0] REG_LED     = 0;
    localparam logic [REG_ADDR_WIDTH-1:0] REG_BUTTONS = 1;
    localparam logic [REG_ADDR_WIDTH-1:0] REG_DUTY0   = 0;
    localparam logic [REG_ADDR_WIDTH-1:0] REG_DUTY1   = 1;
    localparam logic [REG_ADDR_WIDTH-1:0] REG_CTRL    = 2;

    // serial timing, short for fast sim
    localparam int CLKS_PER_BIT = 16;
    localparam int CNT_WIDTH    = $clog2(CLKS_PER_BIT);

    // upper nibble of command byte 0
    typedef enum logic [DBUS_WIDTH-PERIPH_ADDR_WIDTH-1:0] {
        OP_WRITE = 1,
        OP_READ  = 2
    } opcode_t;

    typedef enum logic [2:0] {MS_IDLE, MS_ADDR, MS_DATA, MS_BUS, MS_RESP} master_state_t;

    typedef enum logic [1:0] {US_IDLE, US_START, US_BITS, US_STOP} uart_state_t;

endpackage

`default_nettype wire

/* hba_bus_if.sv */
`default_nettype none

// one instance per peripheral, the master decodes the slot
interface hba_bus_if import hba_pkg::*; ();

    logic                      en;       // one-cycle strobe
    logic                      wr;       // 1 = write, 0 = read
    logic [REG_ADDR_WIDTH-1:0] reg_addr;
    logic [DBUS_WIDTH-1:0]     wdata;
    logic [DBUS_WIDTH-1:0]     rdata;    // registered, valid cycle after en

    modport master (
        output en, wr, reg_addr, wdata,
        input  rdata
    );

    modport periph (
        input  en, wr, reg_addr, wdata,
        output rdata
    );

endinterface

`default_nettype wire

/* uart_rx.sv */
`default_nettype none

module uart_rx import hba_pkg::*; (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  rxd,
    output logic                  rx_valid,
    output logic [DBUS_WIDTH-1:0] rx_data,
    input  logic                  rx_ready
);

    uart_state_t           state;
    logic                  rxd_meta, rxd_sync;   // two-flop sync
    logic [CNT_WIDTH-1:0]  clk_cnt;
    logic [2:0]            bit_cnt;
    logic [DBUS_WIDTH-1:0] shreg;
    logic                  bit_mid;              // centre of a data or stop bit
    logic                  load_byte;

    assign bit_mid   = (clk_cnt == CNT_WIDTH'(CLKS_PER_BIT - 1));
    // good stop bit and the holding byte is free, else the byte is dropped
    assign load_byte = (state == US_STOP) && bit_mid && rxd_sync && (!rx_valid || rx_ready);

    always_ff @(posedge clk) begin
        if (reset) begin
            rxd_meta <= 1'b1;   // line idles high
            rxd_sync <= 1'b1;
        end else begin
            rxd_meta <= rxd;
            rxd_sync <= rxd_meta;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= US_IDLE;
            clk_cnt  <= '0;
            bit_cnt  <= '0;
            rx_valid <= 1'b0;
        end else begin
            clk_cnt <= clk_cnt + 1'b1;
            if (rx_valid && rx_ready)
                rx_valid <= 1'b0;       // handed over
            case (state)
                US_IDLE: begin
                    clk_cnt <= '0;
                    if (!rxd_sync)
                        state <= US_START;   // falling edge seen
                end
                US_START: begin
                    // confirm start bit half a bit later
                    if (clk_cnt == CNT_WIDTH'(CLKS_PER_BIT / 2 - 1)) begin
                        clk_cnt <= '0;
                        bit_cnt <= '0;
                        state   <= rxd_sync ? US_IDLE : US_BITS;   // glitch -> back off
                    end
                end
                US_BITS: begin
                    if (bit_mid) begin
                        bit_cnt <= bit_cnt + 1'b1;
                        if (bit_cnt == 3'd7)
                            state <= US_STOP;
                    end
                end
                US_STOP: begin
                    if (bit_mid)
                        state <= US_IDLE;
                    if (load_byte)
                        rx_valid <= 1'b1;
                end
                default: state <= US_IDLE;
            endcase
        end
    end

    // data path, lsb first
    always_ff @(posedge clk) begin
        if (state == US_BITS && bit_mid)
            shreg <= {rxd_sync, shreg[DBUS_WIDTH-1:1]};
        if (load_byte)
            rx_data <= shreg;
    end

    // held byte must not change until the master takes it
    a_rx_data_stable: assert property (@(posedge clk) disable iff (reset)
        rx_valid && !rx_ready |=> rx_valid && $stable(rx_data));

endmodule

`default_nettype wire

/* uart_tx.sv */
`default_nettype none

module uart_tx import hba_pkg::*; (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  tx_valid,
    input  logic [DBUS_WIDTH-1:0] tx_data,
    output logic                  tx_ready,
    output logic                  txd
);

    uart_state_t           state;
    logic [CNT_WIDTH-1:0]  clk_cnt;
    logic [2:0]            bit_cnt;
    logic [DBUS_WIDTH-1:0] shreg;
    logic                  bit_end;

    assign tx_ready = (state == US_IDLE);
    assign bit_end  = (clk_cnt == CNT_WIDTH'(CLKS_PER_BIT - 1));

    always_ff @(posedge clk) begin
        if (reset) begin
            state   <= US_IDLE;
            txd     <= 1'b1;   // idle mark
            clk_cnt <= '0;
            bit_cnt <= '0;
        end else begin
            clk_cnt <= bit_end ? '0 : clk_cnt + 1'b1;
            case (state)
                US_IDLE: begin
                    clk_cnt <= '0;
                    bit_cnt <= '0;
                    if (tx_valid) begin
                        txd   <= 1'b0;       // start bit next cycle
                        state <= US_START;
                    end
                end
                US_START: if (bit_end) begin
                    txd   <= shreg[0];
                    state <= US_BITS;
                end
                US_BITS: if (bit_end) begin
                    bit_cnt <= bit_cnt + 1'b1;
                    if (bit_cnt == 3'd7) begin
                        txd   <= 1'b1;     // stop bit
                        state <= US_STOP;
                    end else begin
                        txd <= shreg[1];
                    end
                end
                US_STOP: if (bit_end)
                    state <= US_IDLE;
                default: state <= US_IDLE;
            endcase
        end
    end

    // shift register, loaded on transfer
    always_ff @(posedge clk) begin
        if (tx_valid && tx_ready)
            shreg <= tx_data;
        else if (state == US_BITS && bit_end)
            shreg <= shreg >> 1;
    end

endmodule

`default_nettype wire

/* hba_master.sv */
`default_nettype none

module hba_master import hba_pkg::*; (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  rx_valid,
    input  logic [DBUS_WIDTH-1:0] rx_data,
    output logic                  rx_ready,
    output logic                  tx_valid,
    output logic [DBUS_WIDTH-1:0] tx_data,
    input  logic                  tx_ready,
    hba_bus_if.master             bus_basicio,
    hba_bus_if.master             bus_motor
);

    master_state_t                state;
    opcode_t                      op;
    logic                         is_write;
    logic                         bus_phase;   // 0 = en cycle, 1 = rdata cycle
    logic                         rx_xfer;
    logic                         bus_en;
    logic [PERIPH_ADDR_WIDTH-1:0] periph;
    logic [REG_ADDR_WIDTH-1:0]    reg_addr;
    logic [DBUS_WIDTH-1:0]        wdata;
    logic [DBUS_WIDTH-1:0]        resp;

    assign op       = opcode_t'(rx_data[DBUS_WIDTH-1:PERIPH_ADDR_WIDTH]);
    assign rx_ready = (state == MS_IDLE) || (state == MS_ADDR) || (state == MS_DATA);
    assign rx_xfer  = rx_valid && rx_ready;
    assign bus_en   = (state == MS_BUS) && !bus_phase;
    assign tx_valid = (state == MS_RESP);
    assign tx_data  = resp;

    // slot decode, unmapped slots never see en
    assign bus_basicio.en       = bus_en && (periph == BASICIO_PERIPH);
    assign bus_motor.en         = bus_en && (periph == MOTOR_PERIPH);
    assign bus_basicio.wr       = is_write;
    assign bus_motor.wr         = is_write;
    assign bus_basicio.reg_addr = reg_addr;
    assign bus_motor.reg_addr   = reg_addr;
    assign bus_basicio.wdata    = wdata;
    assign bus_motor.wdata      = wdata;

    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= MS_IDLE;
            is_write  <= 1'b0;
            bus_phase <= 1'b0;
        end else begin
            case (state)
                MS_IDLE: if (rx_xfer) begin
                    is_write <= (op == OP_WRITE);
                    if (op == OP_WRITE || op == OP_READ)
                        state <= MS_ADDR;   // unknown opcode stays idle
                end
                MS_ADDR: if (rx_xfer)
                    state <= is_write ? MS_DATA : MS_BUS;
                MS_DATA: if (rx_xfer)
                    state <= MS_BUS;
                MS_BUS: begin
                    if (!bus_phase) begin
                        if (is_write)
                            state <= MS_IDLE;   // write lands at end of en
                        else
                            bus_phase <= 1'b1;
                    end else begin
                        bus_phase <= 1'b0;
                        state     <= MS_RESP;
                    end
                end
                MS_RESP: if (tx_ready)
                    state <= MS_IDLE;   // rx held off until here
                default: state <= MS_IDLE;
            endcase
        end
    end

    // command fields and response byte
    always_ff @(posedge clk) begin
        if (rx_xfer) begin
            case (state)
                MS_IDLE: periph   <= rx_data[PERIPH_ADDR_WIDTH-1:0];
                MS_ADDR: reg_addr <= rx_data;
                MS_DATA: wdata    <= rx_data;
                default: ;
            endcase
        end
        if (state == MS_BUS && bus_phase) begin
            case (periph)
                BASICIO_PERIPH: resp <= bus_basicio.rdata;
                MOTOR_PERIPH:   resp <= bus_motor.rdata;
                default:        resp <= '0;   // empty slot reads 0
            endcase
        end
    end

    a_one_hot_en: assert property (@(posedge clk) disable iff (reset)
        !(bus_basicio.en && bus_motor.en));

    a_tx_hold: assert property (@(posedge clk) disable iff (reset)
        tx_valid && !tx_ready |=> tx_valid && $stable(tx_data));

endmodule

`default_nettype wire

/* hba_basicio.sv */
`default_nettype none

module hba_basicio import hba_pkg::*; (
    input  logic                  clk,
    input  logic                  reset,
    hba_bus_if.periph             bus,
    input  logic [1:0]            buttons,
    output logic [DBUS_WIDTH-1:0] led
);

    logic [1:0] btn_meta;
    logic [1:0] btn_sync;   // async buttons, two flops

    always_ff @(posedge clk) begin
        if (reset) begin
            led      <= '0;
            btn_meta <= '0;
            btn_sync <= '0;
        end else begin
            btn_meta <= buttons;
            btn_sync <= btn_meta;
            if (bus.en && bus.wr && bus.reg_addr == REG_LED)
                led <= bus.wdata;
        end
    end

    // read port, answers in the cycle after en
    always_ff @(posedge clk) begin
        if (bus.en) begin
            case (bus.reg_addr)
                REG_LED:     bus.rdata <= led;
                REG_BUTTONS: bus.rdata <= {{(DBUS_WIDTH-2){1'b0}}, btn_sync};
                default:     bus.rdata <= '0;
            endcase
        end
    end

endmodule

`default_nettype wire

/* hba_motor.sv */
`default_nettype none

module hba_motor import hba_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    hba_bus_if.periph  bus,
    output logic [1:0] motor_pwm,
    output logic [1:0] motor_dir,
    output logic [1:0] motor_float_n
);

    logic [DBUS_WIDTH-1:0] duty0;
    logic [DBUS_WIDTH-1:0] duty1;
    logic [3:0]            ctrl;      // {float_n[1:0], dir[1:0]}
    logic [DBUS_WIDTH-1:0] pwm_cnt;   // free running, wraps at 256
    logic                  wr_en;

    assign wr_en         = bus.en && bus.wr;
    assign motor_dir     = ctrl[1:0];
    assign motor_float_n = ctrl[3:2];   // 0 = coasting

    always_ff @(posedge clk) begin
        if (reset) begin
            duty0     <= '0;
            duty1     <= '0;
            ctrl      <= '0;
            pwm_cnt   <= '0;
            motor_pwm <= '0;
        end else begin
            pwm_cnt <= pwm_cnt + 1'b1;
            // high for duty counts out of 256
            motor_pwm <= {pwm_cnt < duty1, pwm_cnt < duty0};
            if (wr_en) begin
                case (bus.reg_addr)
                    REG_DUTY0: duty0 <= bus.wdata;
                    REG_DUTY1: duty1 <= bus.wdata;
                    REG_CTRL:  ctrl  <= bus.wdata[3:0];
                    default:   ;
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (bus.en) begin
            case (bus.reg_addr)
                REG_DUTY0: bus.rdata <= duty0;
                REG_DUTY1: bus.rdata <= duty1;
                REG_CTRL:  bus.rdata <= {{(DBUS_WIDTH-4){1'b0}}, ctrl};
                default:   bus.rdata <= '0;
            endcase
        end
    end

endmodule

`default_nettype wire

/* hba_system.sv */
`default_nettype none

module hba_system import hba_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  logic       rxd,
    output logic       txd,
    input  logic [1:0] buttons,
    output logic [7:0] led,
    output logic [1:0] motor_pwm,
    output logic [1:0] motor_dir,
    output logic [1:0] motor_float_n
);

    logic                  rx_valid;
    logic [DBUS_WIDTH-1:0] rx_data;
    logic                  rx_ready;
    logic                  tx_valid;
    logic [DBUS_WIDTH-1:0] tx_data;
    logic                  tx_ready;

    hba_bus_if bus_basicio ();   // slot 1
    hba_bus_if bus_motor ();     // slot 3

    uart_rx u_uart_rx (
        .clk      (clk),
        .reset    (reset),
        .rxd      (rxd),
        .rx_valid (rx_valid),
        .rx_data  (rx_data),
        .rx_ready (rx_ready)
    );

    hba_master u_master (
        .clk         (clk),
        .reset       (reset),
        .rx_valid    (rx_valid),
        .rx_data     (rx_data),
        .rx_ready    (rx_ready),
        .tx_valid    (tx_valid),
        .tx_data     (tx_data),
        .tx_ready    (tx_ready),
        .bus_basicio (bus_basicio),
        .bus_motor   (bus_motor)
    );

    hba_basicio u_basicio (
        .clk     (clk),
        .reset   (reset),
        .bus     (bus_basicio),
        .buttons (buttons),
        .led     (led)
    );

    hba_motor u_motor (
        .clk           (clk),
        .reset         (reset),
        .bus           (bus_motor),
        .motor_pwm     (motor_pwm),
        .motor_dir     (motor_dir),
        .motor_float_n (motor_float_n)
    );

    uart_tx u_uart_tx (
        .clk      (clk),
        .reset    (reset),
        .tx_valid (tx_valid),
        .tx_data  (tx_data),
        .tx_ready (tx_ready),
        .txd      (txd)
    );

endmodule

`default_nettype wire

/* tb_hba_system.sv */
`default_nettype none

module tb_hba_system import hba_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int FRAME_CLKS  = 10 * CLKS_PER_BIT;
    localparam int REPLY_LIMIT = 4 * FRAME_CLKS;   // longest command plus reply latency
    localparam int BB_READS    = 6;

    logic       clk = 1'b0;
    logic       reset;
    logic       rxd;
    logic       txd;
    logic [1:0] buttons;
    logic [7:0] led;
    logic [1:0] motor_pwm;
    logic [1:0] motor_dir;
    logic [1:0] motor_float_n;

    int checks;
    int errors;
    int test_base;   // error count at start of current test

    // register model
    logic [7:0] led_m;
    logic [7:0] duty_m [2];
    logic [3:0] ctrl_m;   // {float_n, dir}

    always #20 clk = ~clk;   // 40 ns period

    hba_system dut (
        .clk           (clk),
        .reset         (reset),
        .rxd           (rxd),
        .txd           (txd),
        .buttons       (buttons),
        .led           (led),
        .motor_pwm     (motor_pwm),
        .motor_dir     (motor_dir),
        .motor_float_n (motor_float_n)
    );

    task automatic check(input logic [15:0] actual, input logic [15:0] expected,
                         input string msg);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("FAIL %0t ns: %s, got 0x%0h, expected 0x%0h", $time, msg, actual, expected);
        end
    endtask

    task automatic end_test(input string name);
        $display("test %s finished, %0d errors", name, errors - test_base);
        test_base = errors;
    endtask

    // reply byte per register map, holes and empty slots give 0
    function automatic logic [7:0] expected_read(input logic [3:0] periph,
                                                 input logic [7:0] addr);
        logic [7:0] val;
        val = 8'h00;
        if (periph == BASICIO_PERIPH) begin
            if (addr == 8'd0)
                val = led_m;
            else if (addr == 8'd1)
                val = {6'b0, buttons};   // synced buttons, stable by now
        end else if (periph == MOTOR_PERIPH) begin
            if (addr == 8'd0)
                val = duty_m[0];
            else if (addr == 8'd1)
                val = duty_m[1];
            else if (addr == 8'd2)
                val = {4'b0, ctrl_m};
        end
        return val;
    endfunction

    task automatic update_model(input logic [3:0] periph, input logic [7:0] addr,
                                input logic [7:0] data);
        if (periph == BASICIO_PERIPH && addr == 8'd0) begin
            led_m = data;
        end else if (periph == MOTOR_PERIPH) begin
            if (addr == 8'd0)
                duty_m[0] = data;
            else if (addr == 8'd1)
                duty_m[1] = data;
            else if (addr == 8'd2)
                ctrl_m = data[3:0];   // upper bits dropped
        end
    endtask

    // start, 8 data lsb first, stop
    task automatic send_byte(input logic [7:0] b);
        logic [9:0] frame;
        frame = {1'b1, b, 1'b0};
        for (int i = 0; i < 10; i++) begin
            @(posedge clk);
            rxd <= frame[i];
            repeat (CLKS_PER_BIT - 1) @(posedge clk);
        end
    endtask

    task automatic get_byte(output logic [7:0] b);
        int         waited;
        logic [9:0] frame;
        b      = 8'h00;
        waited = 0;
        @(posedge clk);
        while (txd !== 1'b0 && waited < REPLY_LIMIT) begin
            @(posedge clk);
            waited++;
        end
        if (txd !== 1'b0) begin
            errors++;
            $display("timeout: no reply start bit on txd within %0d cycles", REPLY_LIMIT);
        end else begin
            repeat (CLKS_PER_BIT / 2) @(posedge clk);   // middle of start bit
            frame[0] = txd;
            for (int i = 1; i < 10; i++) begin
                repeat (CLKS_PER_BIT) @(posedge clk);
                frame[i] = txd;
            end
            b = frame[8:1];
            if (frame[0] !== 1'b0 || frame[9] !== 1'b1) begin
                errors++;
                $display("reply frame on txd has a bad start or stop bit at %0t ns", $time);
            end
        end
    endtask

    task automatic write_reg(input logic [3:0] periph, input logic [7:0] addr,
                             input logic [7:0] data);
        send_byte({OP_WRITE, periph});
        send_byte(addr);
        send_byte(data);
        repeat (CLKS_PER_BIT) @(posedge clk);   // stop sample, sync, en all inside a bit
        update_model(periph, addr, data);
    endtask

    task automatic read_reg(input logic [3:0] periph, input logic [7:0] addr,
                            output logic [7:0] data);
        fork   // reply can start before the stop bit ends
            begin
                send_byte({OP_READ, periph});
                send_byte(addr);
            end
            get_byte(data);
        join
    endtask

    task automatic expect_silence(input int cycles, input string msg);
        int seen;
        seen = 0;
        repeat (cycles) begin
            @(posedge clk);
            if (txd !== 1'b1)
                seen++;
        end
        check(16'(seen), 16'd0, msg);
    endtask

    initial begin
        logic [7:0] v;
        logic [7:0] rd;
        logic [7:0] addr;
        logic [3:0] p;
        logic [3:0] op;
        int         cnt0;
        int         cnt1;
        int         k;
        logic [3:0] bb_p [BB_READS];
        logic [7:0] bb_a [BB_READS];
        logic [7:0] bb_r [BB_READS];

        void'($urandom(18313));
        checks    = 0;
        errors    = 0;
        test_base = 0;
        led_m     = 8'h00;
        duty_m[0] = 8'h00;
        duty_m[1] = 8'h00;
        ctrl_m    = 4'h0;
        reset   <= 1'b1;
        rxd     <= 1'b1;   // idle mark
        buttons <= 2'b00;
        repeat (3) @(posedge clk);
        reset <= 1'b0;
        @(posedge clk);

        // reset values
        check(16'(led), 16'h0, "led after reset");
        check(16'(motor_pwm), 16'h0, "motor_pwm after reset");
        check(16'(motor_dir), 16'h0, "motor_dir after reset");
        check(16'(motor_float_n), 16'h0, "motor_float_n after reset");
        check(16'(txd), 16'h1, "txd after reset");
        expect_silence(2 * FRAME_CLKS, "txd activity after reset");
        end_test("reset");

        for (int i = 0; i < 20; i++) begin
            v = 8'($urandom());
            write_reg(BASICIO_PERIPH, 8'd0, v);
            check(16'(led), 16'(led_m), "led pins after write");
            read_reg(BASICIO_PERIPH, 8'd0, rd);
            check(16'(rd), 16'(expected_read(BASICIO_PERIPH, 8'd0)), "led register read");
        end
        end_test("basicio_led");

        for (int i = 0; i < 4; i++) begin
            @(posedge clk);
            buttons <= 2'($urandom());
            read_reg(BASICIO_PERIPH, 8'd1, rd);
            check(16'(rd), 16'(expected_read(BASICIO_PERIPH, 8'd1)), "button register read");
        end
        end_test("buttons");

        for (int i = 0; i < 4; i++) begin
            write_reg(MOTOR_PERIPH, 8'd0, 8'($urandom()));
            write_reg(MOTOR_PERIPH, 8'd1, 8'($urandom()));
            write_reg(MOTOR_PERIPH, 8'd2, 8'($urandom()));   // junk in upper bits
            check(16'(motor_dir), 16'(ctrl_m[1:0]), "motor_dir pins");
            check(16'(motor_float_n), 16'(ctrl_m[3:2]), "motor_float_n pins");
            cnt0 = 0;
            cnt1 = 0;
            repeat (256) begin   // one full pwm period
                @(posedge clk);
                if (motor_pwm[0])
                    cnt0++;
                if (motor_pwm[1])
                    cnt1++;
            end
            check(16'(cnt0), 16'(duty_m[0]), "motor 0 pwm high cycles");
            check(16'(cnt1), 16'(duty_m[1]), "motor 1 pwm high cycles");
            for (int r = 0; r < 3; r++) begin
                read_reg(MOTOR_PERIPH, 8'(r), rd);
                check(16'(rd), 16'(expected_read(MOTOR_PERIPH, 8'(r))), "motor register read");
            end
        end
        end_test("motor");

        for (int i = 0; i < 6; i++) begin
            op = 4'($urandom_range(2, 15));
            if (op == 4'd2)
                op = 4'd0;   // keep 0 and 3..15 only
            send_byte({op, 4'($urandom())});
            expect_silence(2 * FRAME_CLKS, "reply to unknown opcode");
            read_reg(BASICIO_PERIPH, 8'd0, rd);
            check(16'(rd), 16'(led_m), "led read after unknown opcode");
        end
        for (int i = 0; i < 4; i++) begin
            p = 4'($urandom());
            if (p == BASICIO_PERIPH || p == MOTOR_PERIPH)
                p = p + 4'd1;   // step off the mapped slots
            addr = 8'($urandom());
            write_reg(p, addr, 8'($urandom()));
            read_reg(p, addr, rd);
            check(16'(rd), 16'h0, "read of empty slot");
            addr = 8'($urandom_range(2, 255));
            write_reg(BASICIO_PERIPH, addr, 8'($urandom()));
            read_reg(BASICIO_PERIPH, addr, rd);
            check(16'(rd), 16'h0, "read of basicio hole");
            addr = 8'($urandom_range(3, 255));
            write_reg(MOTOR_PERIPH, addr, 8'($urandom()));
            read_reg(MOTOR_PERIPH, addr, rd);
            check(16'(rd), 16'h0, "read of motor hole");
        end
        check(16'(led), 16'(led_m), "led pins after unmapped writes");
        for (int r = 0; r < 3; r++) begin
            read_reg(MOTOR_PERIPH, 8'(r), rd);
            check(16'(rd), 16'(expected_read(MOTOR_PERIPH, 8'(r))), "motor reg after unmapped");
        end
        end_test("unmapped");

        for (int i = 0; i < BB_READS; i++) begin
            k = int'($urandom_range(0, 4));
            bb_p[i] = (k < 2) ? BASICIO_PERIPH : MOTOR_PERIPH;
            bb_a[i] = (k < 2) ? 8'(k) : 8'(k - 2);
        end
        fork
            for (int i = 0; i < BB_READS; i++) begin   // no gap between commands
                send_byte({OP_READ, bb_p[i]});
                send_byte(bb_a[i]);
            end
            for (int j = 0; j < BB_READS; j++)
                get_byte(bb_r[j]);
        join
        for (int i = 0; i < BB_READS; i++)
            check(16'(bb_r[i]), 16'(expected_read(bb_p[i], bb_a[i])), "back-to-back reply");
        end_test("back_to_back");

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* tb.f */
hba_pkg.sv
hba_bus_if.sv
uart_rx.sv
uart_tx.sv
hba_master.sv
hba_basicio.sv
hba_motor.sv
hba_system.sv
tb_hba_system.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    = --timing --assert --timescale 1ns/1ps
TOP       = tb_hba_system
FILELIST  = tb.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "Simulation passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
